// File: user_io_pkg.sv
`default_nettype none

package user_io_pkg;

	localparam int BYTE_W     = 8;
	localparam int BYTE_CNT_W = 10;
	localparam int JOY_W      = 32;
	localparam int JOY_NUM    = 5;
	localparam int STATUS_W   = 64;
	localparam int SD_DRIVES  = 2;
	localparam int LBA_W      = 32;

	// returned on miso while the host sends the command byte
	localparam logic [BYTE_W-1:0] CORE_TYPE = 8'ha4;

	// core capabilities, sent msb first after the 0x80 echo
	localparam logic [31:0] FEATURES_WORD = 32'h0102_0c51;

	localparam logic [3:0] SD_CMD_TAG = 4'h6;

	typedef enum logic [7:0] {
		CMD_NONE      = 8'h00,
		CMD_BUT_SW    = 8'h01,
		CMD_CONF_STR  = 8'h14,
		CMD_STATUS_LO = 8'h15,
		CMD_SD_REQ    = 8'h16,
		CMD_STATUS    = 8'h1e,
		CMD_CORE_MOD  = 8'h21,
		CMD_JOY0      = 8'h60,
		CMD_JOY1      = 8'h61,
		CMD_JOY2      = 8'h62,
		CMD_JOY3      = 8'h63,
		CMD_JOY4      = 8'h64,
		CMD_FEATURES  = 8'h80
	} cmd_e;

	typedef enum logic [2:0] {
		REPLY_ZERO,
		REPLY_CONF,
		REPLY_SD,
		REPLY_FEATURES,
		REPLY_ECHO
	} reply_sel_e;

endpackage

`default_nettype wire

// File: spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
	input  wire                                spi_sck,
	input  wire                                SPI_SS_IO,
	input  wire                                spi_mosi_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      tx_next_i,
	output logic                               spi_miso_o,
	output logic [2:0]                         bit_cnt_o,
	output logic [user_io_pkg::BYTE_CNT_W-1:0] byte_cnt_o,
	output logic                               last_bit_o,
	output logic [user_io_pkg::BYTE_W-1:0]     mosi_byte_o,
	output logic [user_io_pkg::BYTE_W-1:0]     byte_in_o,
	output logic                               byte_valid_o,
	output logic [user_io_pkg::BYTE_CNT_W-1:0] byte_idx_o
);

	logic [6:0]                    sbuf;
	logic [user_io_pkg::BYTE_W-1:0] tx_byte;

	assign last_bit_o  = (bit_cnt_o == 3'd7);
	// msb first with the bit now on mosi completing the byte
	assign mosi_byte_o = {sbuf, spi_mosi_i};

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt_o    <= '0;
			byte_cnt_o   <= '0;
			byte_valid_o <= 1'b0;
			tx_byte      <= user_io_pkg::CORE_TYPE;
		end else begin
			bit_cnt_o    <= bit_cnt_o + 3'd1;
			byte_valid_o <= last_bit_o;
			if (last_bit_o) begin
				tx_byte <= tx_next_i;
				// stays at the top once long transfers run past it
				if (~&byte_cnt_o)
					byte_cnt_o <= byte_cnt_o + 1'b1;
			end
		end
	end

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sbuf       <= '0;
			byte_in_o  <= '0;
			byte_idx_o <= '0;
		end else begin
			if (!last_bit_o)
				sbuf <= {sbuf[5:0], spi_mosi_i};
			if (last_bit_o) begin
				byte_in_o  <= mosi_byte_o;
				byte_idx_o <= byte_cnt_o;
			end
		end
	end

	// host samples on the rising edge, so drive on the falling one
	always_ff @(negedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_miso_o <= 1'b0;
		else
			spi_miso_o <= tx_byte[3'd7 - bit_cnt_o];
	end

	assert property (@(posedge spi_sck) disable iff (SPI_SS_IO)
		byte_valid_o |-> ($past(bit_cnt_o) == 3'd7))
		else $error("byte_valid without a completed byte");

endmodule

`default_nettype wire

// File: cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl (
	input  wire                                spi_sck,
	input  wire                                SPI_SS_IO,
	input  wire                                last_bit_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      mosi_byte_i,
	input  wire [user_io_pkg::BYTE_CNT_W-1:0]  byte_cnt_i,
	input  wire                                byte_valid_i,
	input  wire [user_io_pkg::BYTE_CNT_W-1:0]  byte_idx_i,
	output user_io_pkg::cmd_e                  cmd_o,
	output user_io_pkg::reply_sel_e            reply_sel_o,
	output logic                               sd_capture_o,
	output logic                               but_sw_we_o,
	output logic                               status_lo_we_o,
	output logic                               status_we_o,
	output logic                               core_mod_we_o,
	output logic [user_io_pkg::JOY_NUM-1:0]    joy_we_o,
	output logic [2:0]                         wr_lane_o
);

	function automatic user_io_pkg::cmd_e decode(input logic [user_io_pkg::BYTE_W-1:0] b);
		case (b)
			user_io_pkg::CMD_BUT_SW,
			user_io_pkg::CMD_CONF_STR,
			user_io_pkg::CMD_STATUS_LO,
			user_io_pkg::CMD_SD_REQ,
			user_io_pkg::CMD_STATUS,
			user_io_pkg::CMD_CORE_MOD,
			user_io_pkg::CMD_JOY0,
			user_io_pkg::CMD_JOY1,
			user_io_pkg::CMD_JOY2,
			user_io_pkg::CMD_JOY3,
			user_io_pkg::CMD_JOY4,
			user_io_pkg::CMD_FEATURES: decode = user_io_pkg::cmd_e'(b);
			default:                   decode = user_io_pkg::CMD_NONE;
		endcase
	endfunction

	user_io_pkg::cmd_e                  mosi_cmd;
	user_io_pkg::cmd_e                  cur_cmd;
	logic                               cmd_byte;
	logic [user_io_pkg::BYTE_CNT_W-1:0] data_idx;

	assign cmd_byte     = (byte_cnt_i == '0);
	assign mosi_cmd     = decode(mosi_byte_i);
	// during byte 0 the command is not latched yet
	assign cur_cmd      = cmd_byte ? mosi_cmd : cmd_o;
	assign sd_capture_o = last_bit_i && cmd_byte && (mosi_cmd == user_io_pkg::CMD_SD_REQ);
	assign data_idx     = byte_idx_i - 1'b1;

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			cmd_o <= user_io_pkg::CMD_NONE;
		else if (last_bit_i && cmd_byte)
			cmd_o <= mosi_cmd;
	end

	always_comb begin
		case (cur_cmd)
			user_io_pkg::CMD_CONF_STR: reply_sel_o = user_io_pkg::REPLY_CONF;
			user_io_pkg::CMD_SD_REQ:   reply_sel_o = user_io_pkg::REPLY_SD;
			user_io_pkg::CMD_FEATURES: reply_sel_o = user_io_pkg::REPLY_FEATURES;
			user_io_pkg::CMD_NONE:     reply_sel_o = user_io_pkg::REPLY_ZERO;
			// write commands echo what the host just sent
			default:                   reply_sel_o = user_io_pkg::REPLY_ECHO;
		endcase
	end

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			but_sw_we_o    <= 1'b0;
			status_lo_we_o <= 1'b0;
			status_we_o    <= 1'b0;
			core_mod_we_o  <= 1'b0;
			joy_we_o       <= '0;
			wr_lane_o      <= '0;
		end else begin
			but_sw_we_o    <= 1'b0;
			status_lo_we_o <= 1'b0;
			status_we_o    <= 1'b0;
			core_mod_we_o  <= 1'b0;
			joy_we_o       <= '0;
			if (byte_valid_i && (byte_idx_i != '0)) begin
				wr_lane_o <= data_idx[2:0];
				case (cmd_o)
					user_io_pkg::CMD_BUT_SW:    but_sw_we_o    <= (byte_idx_i == 1);
					user_io_pkg::CMD_STATUS_LO: status_lo_we_o <= (byte_idx_i == 1);
					user_io_pkg::CMD_CORE_MOD:  core_mod_we_o  <= (byte_idx_i == 1);
					user_io_pkg::CMD_STATUS:    status_we_o    <= (byte_idx_i <= 8);
					user_io_pkg::CMD_JOY0,
					user_io_pkg::CMD_JOY1,
					user_io_pkg::CMD_JOY2,
					user_io_pkg::CMD_JOY3,
					user_io_pkg::CMD_JOY4:
						// opcode low bits pick the stick
						if (byte_idx_i <= 4)
							joy_we_o[cmd_o[2:0]] <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge spi_sck) disable iff (SPI_SS_IO)
		$onehot0({but_sw_we_o, status_lo_we_o, status_we_o, core_mod_we_o, joy_we_o}))
		else $error("more than one register write strobe active");

endmodule

`default_nettype wire

// File: host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs (
	input  wire                               spi_sck,
	input  wire [user_io_pkg::BYTE_W-1:0]     byte_i,
	input  wire                               but_sw_we_i,
	input  wire                               status_lo_we_i,
	input  wire                               status_we_i,
	input  wire                               core_mod_we_i,
	input  wire [2:0]                         wr_lane_i,
	output logic [1:0]                        buttons_o,
	output logic [1:0]                        switches_o,
	output logic                              scandoubler_disable_o,
	output logic                              ypbpr_o,
	output logic                              no_csync_o,
	output logic [user_io_pkg::STATUS_W-1:0]  status_o,
	output logic [6:0]                        core_mod_o
);

	logic [user_io_pkg::BYTE_W-1:0] but_sw;

	always_ff @(posedge spi_sck) begin
		if (but_sw_we_i)
			but_sw <= byte_i;
	end

	always_ff @(posedge spi_sck) begin
		if (core_mod_we_i)
			core_mod_o <= byte_i[6:0];
	end

	// 0x15 clears the upper bytes, 0x1e fills lanes lsb first
	always_ff @(posedge spi_sck) begin
		if (status_lo_we_i)
			status_o <= user_io_pkg::STATUS_W'(byte_i);
		else if (status_we_i)
			status_o[{wr_lane_i, 3'b000} +: user_io_pkg::BYTE_W] <= byte_i;
	end

	assign buttons_o             = but_sw[1:0];
	assign switches_o            = but_sw[3:2];
	assign scandoubler_disable_o = but_sw[4];
	assign ypbpr_o               = but_sw[5];
	assign no_csync_o            = but_sw[6];

endmodule

`default_nettype wire

// File: joystick_regs.sv
`timescale 1ns/1ps
`default_nettype none

module joystick_regs (
	input  wire                             spi_sck,
	input  wire [user_io_pkg::BYTE_W-1:0]   byte_i,
	input  wire [user_io_pkg::JOY_NUM-1:0]  joy_we_i,
	input  wire [2:0]                       wr_lane_i,
	output logic [user_io_pkg::JOY_W-1:0]   joystick_0_o,
	output logic [user_io_pkg::JOY_W-1:0]   joystick_1_o,
	output logic [user_io_pkg::JOY_W-1:0]   joystick_2_o,
	output logic [user_io_pkg::JOY_W-1:0]   joystick_3_o,
	output logic [user_io_pkg::JOY_W-1:0]   joystick_4_o
);

	logic [user_io_pkg::JOY_W-1:0] joy_q [user_io_pkg::JOY_NUM];

	// little endian, lane 0 is the first data byte
	always_ff @(posedge spi_sck) begin
		for (int i = 0; i < user_io_pkg::JOY_NUM; i++) begin
			if (joy_we_i[i])
				joy_q[i][{wr_lane_i[1:0], 3'b000} +: user_io_pkg::BYTE_W] <= byte_i;
		end
	end

	assign joystick_0_o = joy_q[0];
	assign joystick_1_o = joy_q[1];
	assign joystick_2_o = joy_q[2];
	assign joystick_3_o = joy_q[3];
	assign joystick_4_o = joy_q[4];

	assert property (@(posedge spi_sck) (|joy_we_i) |-> (wr_lane_i < 3'd4))
		else $error("joystick write lane out of range");

endmodule

`default_nettype wire

// File: sd_request.sv
`timescale 1ns/1ps
`default_nettype none

module sd_request (
	input  wire                                spi_sck,
	input  wire                                SPI_SS_IO,
	input  wire [user_io_pkg::SD_DRIVES-1:0]   sd_rd_i,
	input  wire [user_io_pkg::SD_DRIVES-1:0]   sd_wr_i,
	input  wire                                sd_conf_i,
	input  wire                                sd_sdhc_i,
	input  wire [user_io_pkg::LBA_W-1:0]       sd_lba_i,
	input  wire                                sd_capture_i,
	input  wire [user_io_pkg::BYTE_CNT_W-1:0]  byte_cnt_i,
	output logic [user_io_pkg::BYTE_W-1:0]     sd_byte_o
);

	typedef logic [$clog2(user_io_pkg::SD_DRIVES)-1:0] drive_t;

	drive_t                         drive_sel;
	drive_t                         drive_r;
	logic [user_io_pkg::BYTE_W-1:0] req_byte;
	logic [user_io_pkg::BYTE_W-1:0] req_r;
	logic [user_io_pkg::LBA_W-1:0]  lba_r;

	// highest requesting drive wins
	always_comb begin
		drive_sel = '0;
		for (int i = 0; i < user_io_pkg::SD_DRIVES; i++) begin
			if (sd_rd_i[i] | sd_wr_i[i])
				drive_sel = drive_t'(i);
		end
	end

	assign req_byte = {user_io_pkg::SD_CMD_TAG, sd_conf_i, sd_sdhc_i,
		sd_wr_i[drive_sel], sd_rd_i[drive_sel]};

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			req_r   <= '0;
			drive_r <= '0;
			lba_r   <= '0;
		end else if (sd_capture_i) begin
			req_r   <= req_byte;
			drive_r <= drive_sel;
			lba_r   <= sd_lba_i;
		end
	end

	always_comb begin
		case (byte_cnt_i)
			10'd0:   sd_byte_o = sd_capture_i ? req_byte : req_r;
			10'd1:   sd_byte_o = user_io_pkg::BYTE_W'(drive_r);
			10'd2:   sd_byte_o = lba_r[31:24];
			10'd3:   sd_byte_o = lba_r[23:16];
			10'd4:   sd_byte_o = lba_r[15:8];
			10'd5:   sd_byte_o = lba_r[7:0];
			default: sd_byte_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: reply_mux.sv
`timescale 1ns/1ps
`default_nettype none

module reply_mux (
	input  wire user_io_pkg::reply_sel_e       reply_sel_i,
	input  wire [user_io_pkg::BYTE_CNT_W-1:0]  byte_cnt_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      conf_chr_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      sd_byte_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      mosi_byte_i,
	output logic [user_io_pkg::BYTE_W-1:0]     tx_next_o
);

	logic [user_io_pkg::BYTE_W-1:0] feat_byte;

	// opcode echo first, then the word msb first
	always_comb begin
		case (byte_cnt_i)
			10'd0:   feat_byte = 8'h80;
			10'd1:   feat_byte = user_io_pkg::FEATURES_WORD[31:24];
			10'd2:   feat_byte = user_io_pkg::FEATURES_WORD[23:16];
			10'd3:   feat_byte = user_io_pkg::FEATURES_WORD[15:8];
			10'd4:   feat_byte = user_io_pkg::FEATURES_WORD[7:0];
			default: feat_byte = '0;
		endcase
	end

	always_comb begin
		case (reply_sel_i)
			user_io_pkg::REPLY_CONF:     tx_next_o = conf_chr_i;
			user_io_pkg::REPLY_SD:       tx_next_o = sd_byte_i;
			user_io_pkg::REPLY_FEATURES: tx_next_o = feat_byte;
			user_io_pkg::REPLY_ECHO:     tx_next_o = mosi_byte_i;
			default:                     tx_next_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: user_io.sv
`timescale 1ns/1ps
`default_nettype none

module user_io (
	input  wire                                spi_sck,
	input  wire                                SPI_SS_IO,
	input  wire                                spi_mosi_i,
	input  wire [user_io_pkg::BYTE_W-1:0]      conf_chr_i,
	input  wire [user_io_pkg::SD_DRIVES-1:0]   sd_rd_i,
	input  wire [user_io_pkg::SD_DRIVES-1:0]   sd_wr_i,
	input  wire                                sd_conf_i,
	input  wire                                sd_sdhc_i,
	input  wire [user_io_pkg::LBA_W-1:0]       sd_lba_i,
	output wire                                spi_miso_o,
	output wire [user_io_pkg::BYTE_CNT_W-1:0]  conf_addr_o,
	output wire [1:0]                          buttons_o,
	output wire [1:0]                          switches_o,
	output wire                                scandoubler_disable_o,
	output wire                                ypbpr_o,
	output wire                                no_csync_o,
	output wire [user_io_pkg::STATUS_W-1:0]    status_o,
	output wire [6:0]                          core_mod_o,
	output wire [user_io_pkg::JOY_W-1:0]       joystick_0_o,
	output wire [user_io_pkg::JOY_W-1:0]       joystick_1_o,
	output wire [user_io_pkg::JOY_W-1:0]       joystick_2_o,
	output wire [user_io_pkg::JOY_W-1:0]       joystick_3_o,
	output wire [user_io_pkg::JOY_W-1:0]       joystick_4_o
);

	logic [user_io_pkg::BYTE_CNT_W-1:0] byte_cnt;
	logic                               last_bit;
	logic [user_io_pkg::BYTE_W-1:0]     mosi_byte;
	logic [user_io_pkg::BYTE_W-1:0]     byte_in;
	logic                               byte_valid;
	logic [user_io_pkg::BYTE_CNT_W-1:0] byte_idx;
	logic [user_io_pkg::BYTE_W-1:0]     tx_next;
	logic [user_io_pkg::BYTE_W-1:0]     sd_byte;
	user_io_pkg::reply_sel_e            reply_sel;
	logic                               sd_capture;
	logic                               but_sw_we;
	logic                               status_lo_we;
	logic                               status_we;
	logic                               core_mod_we;
	logic [user_io_pkg::JOY_NUM-1:0]    joy_we;
	logic [2:0]                         wr_lane;

	// the string source is indexed by the byte count
	assign conf_addr_o = byte_cnt;

	spi_shifter spi_shifter_i (
		.spi_sck      (spi_sck),
		.SPI_SS_IO    (SPI_SS_IO),
		.spi_mosi_i   (spi_mosi_i),
		.tx_next_i    (tx_next),
		.spi_miso_o   (spi_miso_o),
		.bit_cnt_o    (),
		.byte_cnt_o   (byte_cnt),
		.last_bit_o   (last_bit),
		.mosi_byte_o  (mosi_byte),
		.byte_in_o    (byte_in),
		.byte_valid_o (byte_valid),
		.byte_idx_o   (byte_idx)
	);

	cmd_ctrl cmd_ctrl_i (
		.spi_sck        (spi_sck),
		.SPI_SS_IO      (SPI_SS_IO),
		.last_bit_i     (last_bit),
		.mosi_byte_i    (mosi_byte),
		.byte_cnt_i     (byte_cnt),
		.byte_valid_i   (byte_valid),
		.byte_idx_i     (byte_idx),
		.cmd_o          (),
		.reply_sel_o    (reply_sel),
		.sd_capture_o   (sd_capture),
		.but_sw_we_o    (but_sw_we),
		.status_lo_we_o (status_lo_we),
		.status_we_o    (status_we),
		.core_mod_we_o  (core_mod_we),
		.joy_we_o       (joy_we),
		.wr_lane_o      (wr_lane)
	);

	host_regs host_regs_i (
		.spi_sck               (spi_sck),
		.byte_i                (byte_in),
		.but_sw_we_i           (but_sw_we),
		.status_lo_we_i        (status_lo_we),
		.status_we_i           (status_we),
		.core_mod_we_i         (core_mod_we),
		.wr_lane_i             (wr_lane),
		.buttons_o             (buttons_o),
		.switches_o            (switches_o),
		.scandoubler_disable_o (scandoubler_disable_o),
		.ypbpr_o               (ypbpr_o),
		.no_csync_o            (no_csync_o),
		.status_o              (status_o),
		.core_mod_o            (core_mod_o)
	);

	joystick_regs joystick_regs_i (
		.spi_sck      (spi_sck),
		.byte_i       (byte_in),
		.joy_we_i     (joy_we),
		.wr_lane_i    (wr_lane),
		.joystick_0_o (joystick_0_o),
		.joystick_1_o (joystick_1_o),
		.joystick_2_o (joystick_2_o),
		.joystick_3_o (joystick_3_o),
		.joystick_4_o (joystick_4_o)
	);

	sd_request sd_request_i (
		.spi_sck      (spi_sck),
		.SPI_SS_IO    (SPI_SS_IO),
		.sd_rd_i      (sd_rd_i),
		.sd_wr_i      (sd_wr_i),
		.sd_conf_i    (sd_conf_i),
		.sd_sdhc_i    (sd_sdhc_i),
		.sd_lba_i     (sd_lba_i),
		.sd_capture_i (sd_capture),
		.byte_cnt_i   (byte_cnt),
		.sd_byte_o    (sd_byte)
	);

	reply_mux reply_mux_i (
		.reply_sel_i (reply_sel),
		.byte_cnt_i  (byte_cnt),
		.conf_chr_i  (conf_chr_i),
		.sd_byte_i   (sd_byte),
		.mosi_byte_i (mosi_byte),
		.tx_next_o   (tx_next)
	);

endmodule

`default_nettype wire

// File: tb_user_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_user_io;

	logic        spi_sck;
	logic        SPI_SS_IO;
	logic        spi_mosi_i;
	logic [7:0]  conf_chr_i;
	logic [1:0]  sd_rd_i;
	logic [1:0]  sd_wr_i;
	logic        sd_conf_i;
	logic        sd_sdhc_i;
	logic [31:0] sd_lba_i;
	wire         spi_miso_o;
	wire  [9:0]  conf_addr_o;
	wire  [1:0]  buttons_o;
	wire  [1:0]  switches_o;
	wire         scandoubler_disable_o;
	wire         ypbpr_o;
	wire         no_csync_o;
	wire  [63:0] status_o;
	wire  [6:0]  core_mod_o;
	wire  [31:0] joystick_0_o;
	wire  [31:0] joystick_1_o;
	wire  [31:0] joystick_2_o;
	wire  [31:0] joystick_3_o;
	wire  [31:0] joystick_4_o;

	logic [7:0]  tx_q [$];
	logic [7:0]  rx_q [$];
	logic [31:0] rng_state;
	logic [31:0] joy_model [5];
	int          checks;
	int          errors;

	user_io user_io_i (.*);

	always #2 spi_sck = ~spi_sck;

	// fake configuration string indexed by the byte count
	function automatic logic [7:0] conf_model(input logic [9:0] addr);
		conf_model = (8'h41 + addr[7:0]) ^ {6'd0, addr[9:8]};
	endfunction

	assign conf_chr_i = conf_model(conf_addr_o);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		xorshift = v;
	endfunction

	task automatic rand_word(output logic [31:0] w);
		rng_state = xorshift(rng_state);
		w = rng_state;
	endtask

	function automatic logic [31:0] joy_out(input int j);
		case (j)
			0:       joy_out = joystick_0_o;
			1:       joy_out = joystick_1_o;
			2:       joy_out = joystick_2_o;
			3:       joy_out = joystick_3_o;
			default: joy_out = joystick_4_o;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// clocks tx_q out msb first and collects miso into rx_q
	task automatic run_transfer(input bit new_lba);
		logic [7:0]  b;
		logic [7:0]  rx_byte;
		logic [31:0] r;
		rx_q.delete();
		rx_byte = '0;
		// select drops in the high phase so the next falling edge drives the first bit
		@(posedge spi_sck);
		#1;
		SPI_SS_IO = 1'b0;
		for (int i = 0; i < tx_q.size(); i++) begin
			b = tx_q[i];
			for (int k = 7; k >= 0; k--) begin
				@(negedge spi_sck);
				if (new_lba && i == 1 && k == 7) begin
					rand_word(r);
					sd_lba_i = r;
				end
				spi_mosi_i = b[k];
				@(posedge spi_sck);
				rx_byte = {rx_byte[6:0], spi_miso_o};
			end
			rx_q.push_back(rx_byte);
		end
		// two more clocks let the last write strobe reach its register
		for (int c = 0; c < 2; c++) begin
			@(negedge spi_sck);
			spi_mosi_i = 1'b0;
		end
		@(negedge spi_sck);
		SPI_SS_IO = 1'b1;
		for (int c = 0; c < 4; c++)
			@(negedge spi_sck);
		compare_value("miso slot 0", 64'(rx_q[0]), 64'(user_io_pkg::CORE_TYPE));
	endtask

	initial begin
		#400000;
		$display("timeout: simulation did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] lba;
		logic [63:0] st;
		logic [7:0]  b;
		logic [7:0]  req;
		logic [6:0]  cm;
		logic        drv;
		spi_sck    = 1'b0;
		SPI_SS_IO  = 1'b1;
		spi_mosi_i = 1'b0;
		sd_rd_i    = '0;
		sd_wr_i    = '0;
		sd_conf_i  = 1'b0;
		sd_sdhc_i  = 1'b0;
		sd_lba_i   = '0;
		rng_state  = 32'h4cba;
		checks     = 0;
		errors     = 0;
		for (int c = 0; c < 8; c++)
			@(negedge spi_sck);
		// joysticks start from their power-up contents
		for (int j = 0; j < 5; j++)
			joy_model[j] = joy_out(j);

		// features word
		tx_q = '{8'h80, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		run_transfer(1'b0);
		compare_value("features slot 1", 64'(rx_q[1]), 64'h80);
		for (int k = 0; k < 4; k++)
			compare_value("features word", 64'(rx_q[2+k]),
				64'(user_io_pkg::FEATURES_WORD[31-8*k -: 8]));

		// buttons and switches
		rand_word(r);
		b = r[7:0];
		tx_q = '{8'h01, b};
		run_transfer(1'b0);
		compare_value("buttons_o", 64'(buttons_o), 64'(b[1:0]));
		compare_value("switches_o", 64'(switches_o), 64'(b[3:2]));
		compare_value("scandoubler_disable_o", 64'(scandoubler_disable_o), 64'(b[4]));
		compare_value("ypbpr_o", 64'(ypbpr_o), 64'(b[5]));
		compare_value("no_csync_o", 64'(no_csync_o), 64'(b[6]));

		// joysticks get six data bytes each and keep only four
		for (int j = 0; j < 5; j++) begin
			tx_q = '{8'h60 + 8'(j)};
			for (int k = 0; k < 6; k++) begin
				rand_word(r);
				tx_q.push_back(r[7:0]);
			end
			joy_model[j] = {tx_q[4], tx_q[3], tx_q[2], tx_q[1]};
			run_transfer(1'b0);
			for (int m = 0; m < 5; m++)
				compare_value($sformatf("joystick_%0d_o", m), 64'(joy_out(m)),
					64'(joy_model[m]));
		end

		// status word followed by core mod and status low byte
		tx_q = '{8'h1e};
		for (int k = 0; k < 9; k++) begin
			rand_word(r);
			tx_q.push_back(r[7:0]);
		end
		for (int k = 0; k < 8; k++)
			st[8*k +: 8] = tx_q[1+k];
		run_transfer(1'b0);
		compare_value("status_o", status_o, st);
		rand_word(r);
		tx_q = '{8'h21, r[7:0]};
		cm = r[6:0];
		run_transfer(1'b0);
		compare_value("core_mod_o", 64'(core_mod_o), 64'(cm));
		compare_value("status_o", status_o, st);
		rand_word(r);
		tx_q = '{8'h15, r[7:0]};
		st = 64'(r[7:0]);
		run_transfer(1'b0);
		compare_value("status_o", status_o, st);
		compare_value("core_mod_o", 64'(core_mod_o), 64'(cm));
		compare_value("buttons_o", 64'(buttons_o), 64'(b[1:0]));
		compare_value("joystick_4_o", 64'(joystick_4_o), 64'(joy_model[4]));

		// configuration string
		tx_q = '{8'h14, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff};
		run_transfer(1'b0);
		for (int k = 1; k < 7; k++)
			compare_value("conf char", 64'(rx_q[k]), 64'(conf_model(10'(k - 1))));

		// sd requests with the lba changing after the command byte
		for (int t = 0; t < 6; t++) begin
			@(negedge spi_sck);
			rand_word(r);
			sd_rd_i   = r[1:0];
			sd_wr_i   = r[3:2];
			sd_conf_i = r[4];
			sd_sdhc_i = r[5];
			rand_word(lba);
			sd_lba_i  = lba;
			drv = sd_rd_i[1] | sd_wr_i[1];
			req = {4'h6, sd_conf_i, sd_sdhc_i, sd_wr_i[drv], sd_rd_i[drv]};
			tx_q = '{8'h16, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
			run_transfer(1'b1);
			compare_value("sd request", 64'(rx_q[1]), 64'(req));
			compare_value("sd drive", 64'(rx_q[2]), 64'(drv));
			for (int k = 0; k < 4; k++)
				compare_value("sd lba", 64'(rx_q[3+k]), 64'(lba[31-8*k -: 8]));
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
user_io_pkg.sv
spi_shifter.sv
cmd_ctrl.sv
host_regs.sv
joystick_regs.sv
sd_request.sv
reply_mux.sv
user_io.sv
tb_user_io.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_user_io -o sim_tb_user_io

out=$(./obj_dir/sim_tb_user_io)
echo "$out"

echo "$out" | grep -q "TEST PASS"
